// File: hdl/decode_pkg.sv
package decode_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Widths fixed by the instruction set
   ////////////////////////////////////////////////////////////////////////////

   localparam int WORD_W       = 32;
   localparam int REG_ADDR_W   = 5;
   localparam int REG_COUNT    = 1 << REG_ADDR_W;
   localparam int OPCODE_W     = 6;
   localparam int FUNC_W       = 6;
   localparam int IMM_W        = 16;
   localparam int SHAMT_W      = 5;
   localparam int JUMP_INDEX_W = 26;
   localparam int ALU_OP_W     = 4;

   typedef logic [WORD_W-1:0]       word_t;
   typedef logic [REG_ADDR_W-1:0]   reg_addr_t;
   typedef logic [OPCODE_W-1:0]     opcode_t;
   typedef logic [FUNC_W-1:0]       func_t;
   typedef logic [IMM_W-1:0]        imm_t;
   typedef logic [SHAMT_W-1:0]      shamt_t;
   typedef logic [JUMP_INDEX_W-1:0] jump_index_t;
   typedef logic [ALU_OP_W-1:0]     alu_op_t;

   // Primary opcodes
   localparam opcode_t OP_RTYPE = 6'b000000;
   localparam opcode_t OP_LB    = 6'b100000;
   localparam opcode_t OP_LH    = 6'b100001;
   localparam opcode_t OP_LW    = 6'b100011;
   localparam opcode_t OP_LBU   = 6'b100100;
   localparam opcode_t OP_LHU   = 6'b100101;
   localparam opcode_t OP_LWU   = 6'b100111;
   localparam opcode_t OP_SB    = 6'b101000;
   localparam opcode_t OP_SH    = 6'b101001;
   localparam opcode_t OP_SW    = 6'b101011;
   localparam opcode_t OP_ADDI  = 6'b001001;
   localparam opcode_t OP_ANDI  = 6'b001100;
   localparam opcode_t OP_ORI   = 6'b001101;
   localparam opcode_t OP_XORI  = 6'b001110;
   localparam opcode_t OP_LUI   = 6'b001111;
   localparam opcode_t OP_SLTI  = 6'b001010;
   localparam opcode_t OP_BEQ   = 6'b000100;
   localparam opcode_t OP_BNE   = 6'b000101;
   localparam opcode_t OP_J     = 6'b000010;
   localparam opcode_t OP_JAL   = 6'b000011;
   localparam opcode_t OP_HLT   = 6'b111111;

   // R-type function codes
   localparam func_t FN_SLL  = 6'b000000;
   localparam func_t FN_SRL  = 6'b000010;
   localparam func_t FN_SRA  = 6'b000011;
   localparam func_t FN_SLLV = 6'b000100;
   localparam func_t FN_SRLV = 6'b000110;
   localparam func_t FN_SRAV = 6'b000111;
   localparam func_t FN_ADDU = 6'b100001;
   localparam func_t FN_SUBU = 6'b100011;
   localparam func_t FN_AND  = 6'b100100;
   localparam func_t FN_OR   = 6'b100101;
   localparam func_t FN_XOR  = 6'b100110;
   localparam func_t FN_NOR  = 6'b100111;
   localparam func_t FN_SLT  = 6'b101010;
   localparam func_t FN_JR   = 6'b001000;
   localparam func_t FN_JALR = 6'b001001;

   // ALU operations with code 9 left unused
   localparam alu_op_t ALU_ADD = 4'd0;
   localparam alu_op_t ALU_SUB = 4'd1;
   localparam alu_op_t ALU_AND = 4'd2;
   localparam alu_op_t ALU_OR  = 4'd3;
   localparam alu_op_t ALU_XOR = 4'd4;
   localparam alu_op_t ALU_NOR = 4'd5;
   localparam alu_op_t ALU_SRL = 4'd6;
   localparam alu_op_t ALU_SLL = 4'd7;
   localparam alu_op_t ALU_SRA = 4'd8;
   localparam alu_op_t ALU_SLT = 4'd10;
   localparam alu_op_t ALU_LUI = 4'd11;

   // Return address register for JAL
   localparam reg_addr_t LINK_REG = 5'd31;

   ////////////////////////////////////////////////////////////////////////////
   // Control frames
   ////////////////////////////////////////////////////////////////////////////

   typedef struct packed {
      alu_op_t    alu_op;
      logic       imm_sel;
      logic       zero_ext;
      logic       use_shamt;
   } ex_ctrl_t;

   // size is 0 byte, 1 half, 2 word
   typedef struct packed {
      logic       rd_en;
      logic       wr_en;
      logic       unsigned_ld;
      logic [1:0] size;
   } mem_ctrl_t;

   typedef struct packed {
      reg_addr_t  dest;
      logic       reg_we;
      logic       from_alu;
      logic       link_pc;
   } wb_ctrl_t;

   typedef struct packed {
      logic       is_branch;
      logic       branch_ne;
      logic       jump_reg;
      logic       jump_imm;
   } dec_flags_t;

endpackage

// File: hdl/decode_control.sv
`timescale 1ns/1ns

module decode_control
   import decode_pkg::*;
   (
   input  opcode_t    i_opcode,
   input  func_t      i_func,
   input  reg_addr_t  i_rt,
   input  reg_addr_t  i_rd,
   output ex_ctrl_t   o_ex,
   output mem_ctrl_t  o_mem,
   output wb_ctrl_t   o_wb,
   output dec_flags_t o_flags,
   output logic       o_rtype
   );

   // Function table results
   alu_op_t fn_alu_op;
   logic    fn_known;
   logic    fn_shamt;
   logic    fn_jump;
   logic    fn_link;

   wb_ctrl_t wb_raw;

   // Byte, half or word from the low opcode bits
   function automatic logic [1:0] access_size(input opcode_t op);
      case (op[1:0])
         2'b00:   return 2'd0;
         2'b01:   return 2'd1;
         default: return 2'd2;
      endcase
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // R-type function table
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      fn_alu_op = ALU_ADD;
      fn_known  = 1'b1;
      fn_shamt  = 1'b0;
      fn_jump   = 1'b0;
      fn_link   = 1'b0;
      case (i_func)
         FN_SLL:  begin fn_alu_op = ALU_SLL; fn_shamt = 1'b1; end
         FN_SRL:  begin fn_alu_op = ALU_SRL; fn_shamt = 1'b1; end
         FN_SRA:  begin fn_alu_op = ALU_SRA; fn_shamt = 1'b1; end
         FN_SLLV: fn_alu_op = ALU_SLL;
         FN_SRLV: fn_alu_op = ALU_SRL;
         FN_SRAV: fn_alu_op = ALU_SRA;
         FN_ADDU: fn_alu_op = ALU_ADD;
         FN_SUBU: fn_alu_op = ALU_SUB;
         FN_AND:  fn_alu_op = ALU_AND;
         FN_OR:   fn_alu_op = ALU_OR;
         FN_XOR:  fn_alu_op = ALU_XOR;
         FN_NOR:  fn_alu_op = ALU_NOR;
         FN_SLT:  fn_alu_op = ALU_SLT;
         FN_JR:   fn_jump = 1'b1;
         FN_JALR: begin fn_jump = 1'b1; fn_link = 1'b1; end
         default: fn_known = 1'b0;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // Primary opcode table
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      o_ex    = '0;
      o_mem   = '0;
      wb_raw  = '0;
      o_flags = '0;
      case (i_opcode)
         OP_RTYPE: begin
            if (fn_known) begin
               o_ex.alu_op      = fn_alu_op;
               o_ex.use_shamt   = fn_shamt;
               wb_raw.dest      = i_rd;
               wb_raw.reg_we    = 1'b1;
               wb_raw.from_alu  = 1'b1;
               wb_raw.link_pc   = fn_link;
               o_flags.jump_reg = fn_jump;
            end
         end
         OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU: begin
            o_ex.imm_sel      = 1'b1;
            o_mem.rd_en       = 1'b1;
            o_mem.unsigned_ld = i_opcode[2];
            o_mem.size        = access_size(i_opcode);
            wb_raw.dest       = i_rt;
            wb_raw.reg_we     = 1'b1;
         end
         OP_SB, OP_SH, OP_SW: begin
            o_ex.imm_sel = 1'b1;
            o_mem.wr_en  = 1'b1;
            o_mem.size   = access_size(i_opcode);
         end
         OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
            o_ex.imm_sel    = 1'b1;
            wb_raw.dest     = i_rt;
            wb_raw.reg_we   = 1'b1;
            wb_raw.from_alu = 1'b1;
            case (i_opcode)
               OP_ADDI: o_ex.alu_op = ALU_ADD;
               OP_SLTI: o_ex.alu_op = ALU_SLT;
               OP_ANDI: o_ex.alu_op = ALU_AND;
               OP_ORI:  o_ex.alu_op = ALU_OR;
               OP_XORI: o_ex.alu_op = ALU_XOR;
               default: o_ex.alu_op = ALU_LUI;
            endcase
            // Logical ops and LUI take the immediate unsigned
            o_ex.zero_ext = (i_opcode != OP_ADDI) && (i_opcode != OP_SLTI);
         end
         OP_BEQ, OP_BNE: begin
            o_ex.imm_sel      = 1'b1;
            o_flags.is_branch = 1'b1;
            o_flags.branch_ne = (i_opcode == OP_BNE);
         end
         OP_J: begin
            o_flags.jump_imm = 1'b1;
         end
         OP_JAL: begin
            o_flags.jump_imm = 1'b1;
            wb_raw.dest      = LINK_REG;
            wb_raw.reg_we    = 1'b1;
            wb_raw.link_pc   = 1'b1;
         end
         default: ;
      endcase
   end

   // Register 0 is never written
   always_comb begin
      o_wb        = wb_raw;
      o_wb.reg_we = wb_raw.reg_we && (wb_raw.dest != '0);
   end

   assign o_rtype = (i_opcode == OP_RTYPE);

endmodule

// File: hdl/register_file.sv
`timescale 1ns/1ns

module register_file
   import decode_pkg::*;
   (
   input  logic      i_clk,
   input  logic      i_rst,
   input  logic      i_we,
   input  reg_addr_t i_waddr,
   input  word_t     i_wdata,
   input  reg_addr_t i_raddr_a,
   input  reg_addr_t i_raddr_b,
   output word_t     o_rdata_a,
   output word_t     o_rdata_b
   );

   word_t regs [REG_COUNT];

   // Falling-edge write so a same-cycle read sees the new word
   always_ff @(negedge i_clk) begin
      if (i_rst) begin
         for (int i = 0; i < REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (i_we) begin
         regs[i_waddr] <= i_wdata;
      end
   end

   assign o_rdata_a = regs[i_raddr_a];
   assign o_rdata_b = regs[i_raddr_b];

endmodule

// File: hdl/branch_resolve.sv
`timescale 1ns/1ns

module branch_resolve
   import decode_pkg::*;
   (
   input  word_t      i_rdata_a,
   input  word_t      i_rdata_b,
   input  logic       i_fwd_sel_a,
   input  logic       i_fwd_sel_b,
   input  word_t      i_fwd_data_a,
   input  word_t      i_fwd_data_b,
   input  dec_flags_t i_flags,
   output logic       o_branch_taken,
   output logic       o_jump_reg_taken,
   output logic       o_jump_imm_taken,
   output logic       o_redirect
   );

   word_t cmp_a;
   word_t cmp_b;
   logic  equal;

   // Forwarded operands win over the register file
   assign cmp_a = i_fwd_sel_a ? i_fwd_data_a : i_rdata_a;
   assign cmp_b = i_fwd_sel_b ? i_fwd_data_b : i_rdata_b;
   assign equal = (cmp_a == cmp_b);

   // BNE inverts the sense of the compare
   assign o_branch_taken   = i_flags.is_branch && (equal ^ i_flags.branch_ne);
   assign o_jump_reg_taken = i_flags.jump_reg;
   assign o_jump_imm_taken = i_flags.jump_imm;

   // Any change of flow flushes the next stage
   assign o_redirect = o_branch_taken | o_jump_reg_taken | o_jump_imm_taken;

endmodule

// File: hdl/id_ex_latch.sv
`timescale 1ns/1ns

module id_ex_latch
   import decode_pkg::*;
   (
   input  logic      i_clk,
   input  logic      i_rst,
   input  logic      i_advance,
   input  ex_ctrl_t  i_ex,
   input  mem_ctrl_t i_mem,
   input  wb_ctrl_t  i_wb,
   input  word_t     i_a,
   input  word_t     i_b,
   input  imm_t      i_imm,
   input  shamt_t    i_shamt,
   input  word_t     i_pc,
   input  logic      i_redirect,
   output ex_ctrl_t  o_ex,
   output mem_ctrl_t o_mem,
   output wb_ctrl_t  o_wb,
   output word_t     o_a,
   output word_t     o_b,
   output imm_t      o_imm,
   output shamt_t    o_shamt,
   output word_t     o_pc,
   output logic      o_nop
   );

   ////////////////////////////////////////////////////////////////////////////
   // ID/EX stage register
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_ex    <= '0;
         o_mem   <= '0;
         o_wb    <= '0;
         o_a     <= '0;
         o_b     <= '0;
         o_imm   <= '0;
         o_shamt <= '0;
         o_pc    <= '0;
         o_nop   <= 1'b0;
      end else if (i_advance) begin
         o_ex    <= i_ex;
         o_mem   <= i_mem;
         o_wb    <= i_wb;
         o_a     <= i_a;
         o_b     <= i_b;
         o_imm   <= i_imm;
         o_shamt <= i_shamt;
         o_pc    <= i_pc;
         // Flush for the instruction behind a taken redirect
         o_nop   <= i_redirect;
      end
   end

endmodule

// File: hdl/instruction_decode.sv
`timescale 1ns/1ns

module instruction_decode
   import decode_pkg::*;
   (
   input  logic        i_clk,
   input  logic        i_rst,
   input  logic        i_valid,
   input  word_t       i_instruction,
   input  word_t       i_pc,
   input  logic        i_regfile_we,
   input  reg_addr_t   i_regfile_addr,
   input  word_t       i_regfile_data,
   input  logic        i_fwd_sel_a,
   input  logic        i_fwd_sel_b,
   input  word_t       i_fwd_data_a,
   input  word_t       i_fwd_data_b,
   output ex_ctrl_t    o_ex_ctrl,
   output mem_ctrl_t   o_mem_ctrl,
   output wb_ctrl_t    o_wb_ctrl,
   output word_t       o_a,
   output word_t       o_b,
   output word_t       o_pc,
   output imm_t        o_imm,
   output shamt_t      o_shamt,
   output logic        o_nop,
   output logic        o_rtype,
   output logic        o_store,
   output logic        o_branch,
   output logic        o_branch_taken,
   output logic        o_jump_reg,
   output word_t       o_jump_reg_addr,
   output logic        o_jump_imm,
   output jump_index_t o_jump_index,
   output logic        o_halt
   );

   // Instruction fields
   opcode_t   opcode;
   reg_addr_t rs;
   reg_addr_t rt;
   reg_addr_t rd;
   shamt_t    shamt;
   func_t     func;
   imm_t      imm;

   logic       advance;
   ex_ctrl_t   ex;
   mem_ctrl_t  mem;
   wb_ctrl_t   wb;
   dec_flags_t flags;
   word_t      rdata_a;
   word_t      rdata_b;
   logic       redirect;

   assign opcode       = i_instruction[31:26];
   assign rs           = i_instruction[25:21];
   assign rt           = i_instruction[20:16];
   assign rd           = i_instruction[15:11];
   assign shamt        = i_instruction[10:6];
   assign func         = i_instruction[5:0];
   assign imm          = i_instruction[15:0];
   assign o_jump_index = i_instruction[25:0];

   // HLT stalls the stage
   assign advance = i_valid && (opcode != OP_HLT);
   assign o_halt  = i_valid && (opcode == OP_HLT);

   decode_control u_control (
      .i_opcode (opcode),
      .i_func   (func),
      .i_rt     (rt),
      .i_rd     (rd),
      .o_ex     (ex),
      .o_mem    (mem),
      .o_wb     (wb),
      .o_flags  (flags),
      .o_rtype  (o_rtype)
   );

   register_file u_regfile (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_we      (advance && i_regfile_we),
      .i_waddr   (i_regfile_addr),
      .i_wdata   (i_regfile_data),
      .i_raddr_a (rs),
      .i_raddr_b (rt),
      .o_rdata_a (rdata_a),
      .o_rdata_b (rdata_b)
   );

   branch_resolve u_branch (
      .i_rdata_a        (rdata_a),
      .i_rdata_b        (rdata_b),
      .i_fwd_sel_a      (i_fwd_sel_a),
      .i_fwd_sel_b      (i_fwd_sel_b),
      .i_fwd_data_a     (i_fwd_data_a),
      .i_fwd_data_b     (i_fwd_data_b),
      .i_flags          (flags),
      .o_branch_taken   (o_branch_taken),
      .o_jump_reg_taken (o_jump_reg),
      .o_jump_imm_taken (o_jump_imm),
      .o_redirect       (redirect)
   );

   id_ex_latch u_latch (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_advance  (advance),
      .i_ex       (ex),
      .i_mem      (mem),
      .i_wb       (wb),
      .i_a        (rdata_a),
      .i_b        (rdata_b),
      .i_imm      (imm),
      .i_shamt    (shamt),
      .i_pc       (i_pc),
      .i_redirect (redirect),
      .o_ex       (o_ex_ctrl),
      .o_mem      (o_mem_ctrl),
      .o_wb       (o_wb_ctrl),
      .o_a        (o_a),
      .o_b        (o_b),
      .o_imm      (o_imm),
      .o_shamt    (o_shamt),
      .o_pc       (o_pc),
      .o_nop      (o_nop)
   );

   // Decode-cycle views for the fetch side
   assign o_store         = mem.wr_en;
   assign o_branch        = flags.is_branch;
   assign o_jump_reg_addr = rdata_a;

endmodule

// File: sim/decode_assert.sv
`timescale 1ns/1ns

module decode_assert
   import decode_pkg::*;
   (
   input logic      i_clk,
   input logic      i_rst,
   input logic      i_valid,
   input word_t     i_instruction,
   input ex_ctrl_t  o_ex_ctrl,
   input mem_ctrl_t o_mem_ctrl,
   input wb_ctrl_t  o_wb_ctrl,
   input word_t     o_a,
   input word_t     o_b,
   input word_t     o_pc,
   input imm_t      o_imm,
   input shamt_t    o_shamt,
   input logic      o_nop,
   input logic      o_halt
   );

   logic [137:0] stage_regs;
   logic         stalled;
   logic         hlt_seen;

   assign stage_regs = {o_ex_ctrl, o_mem_ctrl, o_wb_ctrl, o_a, o_b, o_pc,
                        o_imm, o_shamt, o_nop};
   assign hlt_seen   = i_instruction[31:26] == OP_HLT;
   assign stalled    = !i_valid || hlt_seen;

   ////////////////////////////////////////////////////////////////////////////
   // Reset, hold and halt
   ////////////////////////////////////////////////////////////////////////////

   // First cycle out of reset
   a_reset_clear: assert property (@(posedge i_clk)
      $fell(i_rst) |-> (stage_regs == '0))
      else $error("stage register not cleared by reset");

   a_hold: assert property (@(posedge i_clk) disable iff (i_rst)
      stalled |=> $stable(stage_regs))
      else $error("stage register changed while the stage was stalled");

   a_halt_high: assert property (@(posedge i_clk) disable iff (i_rst)
      (i_valid && hlt_seen) |-> o_halt)
      else $error("halt output low during a valid HLT");

   a_halt_low: assert property (@(posedge i_clk) disable iff (i_rst)
      !(i_valid && hlt_seen) |-> !o_halt)
      else $error("halt output high without a valid HLT");

endmodule

bind instruction_decode decode_assert u_decode_assert (
   .i_clk         (i_clk),
   .i_rst         (i_rst),
   .i_valid       (i_valid),
   .i_instruction (i_instruction),
   .o_ex_ctrl     (o_ex_ctrl),
   .o_mem_ctrl    (o_mem_ctrl),
   .o_wb_ctrl     (o_wb_ctrl),
   .o_a           (o_a),
   .o_b           (o_b),
   .o_pc          (o_pc),
   .o_imm         (o_imm),
   .o_shamt       (o_shamt),
   .o_nop         (o_nop),
   .o_halt        (o_halt)
);

// File: sim/tb_instruction_decode.sv
`timescale 1ns/1ns

module tb_instruction_decode
   import decode_pkg::*;
   ();

   localparam int CYCLE_LIMIT = 400;

   logic  i_clk;
   logic  i_rst;
   logic  i_valid;
   word_t i_instruction;
   word_t i_pc;
   logic  i_regfile_we;
   reg_addr_t i_regfile_addr;
   word_t i_regfile_data;
   logic  i_fwd_sel_a;
   logic  i_fwd_sel_b;
   word_t i_fwd_data_a;
   word_t i_fwd_data_b;

   ex_ctrl_t    o_ex_ctrl;
   mem_ctrl_t   o_mem_ctrl;
   wb_ctrl_t    o_wb_ctrl;
   word_t       o_a;
   word_t       o_b;
   word_t       o_pc;
   imm_t        o_imm;
   shamt_t      o_shamt;
   logic        o_nop;
   logic        o_rtype;
   logic        o_store;
   logic        o_branch;
   logic        o_branch_taken;
   logic        o_jump_reg;
   word_t       o_jump_reg_addr;
   logic        o_jump_imm;
   jump_index_t o_jump_index;
   logic        o_halt;

   integer seed;
   int     cycle_count;

   instruction_decode UUT (.*);

   initial begin
      i_clk = 1'b0;
      forever #4 i_clk = ~i_clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////////////////////

   opcode_t    op;
   func_t      fn;
   reg_addr_t  f_rs;
   reg_addr_t  f_rt;
   logic       m_adv;
   logic       m_taken;
   logic       m_fn_known;
   ex_ctrl_t   m_ex;
   mem_ctrl_t  m_mem;
   wb_ctrl_t   m_wb;
   dec_flags_t m_flags;
   word_t      cmp_a;
   word_t      cmp_b;
   word_t      shadow [32];

   assign op    = i_instruction[31:26];
   assign fn    = i_instruction[5:0];
   assign f_rs  = i_instruction[25:21];
   assign f_rt  = i_instruction[20:16];
   assign m_adv = i_valid && (op != OP_HLT);
   assign cmp_a = i_fwd_sel_a ? i_fwd_data_a : shadow[f_rs];
   assign cmp_b = i_fwd_sel_b ? i_fwd_data_b : shadow[f_rt];

   always_comb begin
      m_ex = '0;
      m_mem = '0;
      m_wb = '0;
      m_flags = '0;
      m_fn_known = 1'b1;
      if (op == OP_RTYPE) begin
         case (fn)
            FN_SLL:  m_ex = '{ALU_SLL, 1'b0, 1'b0, 1'b1};
            FN_SRL:  m_ex = '{ALU_SRL, 1'b0, 1'b0, 1'b1};
            FN_SRA:  m_ex = '{ALU_SRA, 1'b0, 1'b0, 1'b1};
            FN_SLLV: m_ex.alu_op = ALU_SLL;
            FN_SRLV: m_ex.alu_op = ALU_SRL;
            FN_SRAV: m_ex.alu_op = ALU_SRA;
            FN_ADDU: m_ex.alu_op = ALU_ADD;
            FN_SUBU: m_ex.alu_op = ALU_SUB;
            FN_AND:  m_ex.alu_op = ALU_AND;
            FN_OR:   m_ex.alu_op = ALU_OR;
            FN_XOR:  m_ex.alu_op = ALU_XOR;
            FN_NOR:  m_ex.alu_op = ALU_NOR;
            FN_SLT:  m_ex.alu_op = ALU_SLT;
            FN_JR:   m_flags.jump_reg = 1'b1;
            FN_JALR: m_flags.jump_reg = 1'b1;
            default: m_fn_known = 1'b0;
         endcase
         if (m_fn_known) begin
            m_wb = '{i_instruction[15:11], 1'b1, 1'b1, fn == FN_JALR};
         end
      end else if (op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU,
                              OP_SB, OP_SH, OP_SW}) begin
         m_ex.imm_sel = 1'b1;
         if (op inside {OP_LB, OP_LBU, OP_SB})
            m_mem.size = 2'd0;
         else if (op inside {OP_LH, OP_LHU, OP_SH})
            m_mem.size = 2'd1;
         else
            m_mem.size = 2'd2;
         if (op inside {OP_SB, OP_SH, OP_SW}) begin
            m_mem.wr_en = 1'b1;
         end else begin
            m_mem.rd_en = 1'b1;
            m_mem.unsigned_ld = op inside {OP_LBU, OP_LHU, OP_LWU};
            m_wb = '{f_rt, 1'b1, 1'b0, 1'b0};
         end
      end else if (op inside {OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI}) begin
         m_ex.imm_sel = 1'b1;
         m_ex.zero_ext = !(op inside {OP_ADDI, OP_SLTI});
         m_ex.alu_op = (op == OP_ADDI) ? ALU_ADD : (op == OP_SLTI) ? ALU_SLT :
                       (op == OP_ANDI) ? ALU_AND : (op == OP_ORI) ? ALU_OR :
                       (op == OP_XORI) ? ALU_XOR : ALU_LUI;
         m_wb = '{f_rt, 1'b1, 1'b1, 1'b0};
      end else if (op == OP_BEQ || op == OP_BNE) begin
         m_ex.imm_sel = 1'b1;
         m_flags.is_branch = 1'b1;
         m_flags.branch_ne = (op == OP_BNE);
      end else if (op == OP_J) begin
         m_flags.jump_imm = 1'b1;
      end else if (op == OP_JAL) begin
         m_flags.jump_imm = 1'b1;
         m_wb = '{LINK_REG, 1'b1, 1'b0, 1'b1};
      end
      if (m_wb.dest == 5'd0)
         m_wb.reg_we = 1'b0;
      m_taken = m_flags.is_branch && ((cmp_a == cmp_b) != m_flags.branch_ne);
   end

   // Expected stage register and register contents
   ex_ctrl_t  exp_ex;
   mem_ctrl_t exp_mem;
   wb_ctrl_t  exp_wb;
   word_t     exp_a;
   word_t     exp_b;
   word_t     exp_pc;
   imm_t      exp_imm;
   shamt_t    exp_shamt;
   logic      exp_nop;

   always @(posedge i_clk) begin
      if (i_rst) begin
         for (int i = 0; i < 32; i++) begin
            shadow[i] <= '0;
         end
         {exp_ex, exp_mem, exp_wb, exp_a, exp_b, exp_pc} <= '0;
         {exp_imm, exp_shamt, exp_nop} <= '0;
      end else if (m_adv) begin
         if (i_regfile_we)
            shadow[i_regfile_addr] <= i_regfile_data;
         exp_ex    <= m_ex;
         exp_mem   <= m_mem;
         exp_wb    <= m_wb;
         exp_a     <= shadow[f_rs];
         exp_b     <= shadow[f_rt];
         exp_pc    <= i_pc;
         exp_imm   <= i_instruction[15:0];
         exp_shamt <= i_instruction[10:6];
         exp_nop   <= m_taken || m_flags.jump_reg || m_flags.jump_imm;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////////////////////

   task automatic report_mismatch(input string name, input word_t got, input word_t want);
      $display("mismatch %s: got %h expected %h", name, got, want);
      $display("Simulation FAILED");
      $fatal(1);
   endtask

   a_ex: assert property (@(posedge i_clk) disable iff (i_rst) o_ex_ctrl == exp_ex)
      else report_mismatch("o_ex_ctrl", 32'($sampled(o_ex_ctrl)), 32'($sampled(exp_ex)));
   a_mem: assert property (@(posedge i_clk) disable iff (i_rst) o_mem_ctrl == exp_mem)
      else report_mismatch("o_mem_ctrl", 32'($sampled(o_mem_ctrl)), 32'($sampled(exp_mem)));
   a_wb: assert property (@(posedge i_clk) disable iff (i_rst) o_wb_ctrl == exp_wb)
      else report_mismatch("o_wb_ctrl", 32'($sampled(o_wb_ctrl)), 32'($sampled(exp_wb)));
   a_a: assert property (@(posedge i_clk) disable iff (i_rst) o_a == exp_a)
      else report_mismatch("o_a", $sampled(o_a), $sampled(exp_a));
   a_b: assert property (@(posedge i_clk) disable iff (i_rst) o_b == exp_b)
      else report_mismatch("o_b", $sampled(o_b), $sampled(exp_b));
   a_pc: assert property (@(posedge i_clk) disable iff (i_rst) o_pc == exp_pc)
      else report_mismatch("o_pc", $sampled(o_pc), $sampled(exp_pc));
   a_imm: assert property (@(posedge i_clk) disable iff (i_rst)
      {o_imm, o_shamt} == {exp_imm, exp_shamt})
      else report_mismatch("o_imm/o_shamt", 32'($sampled({o_imm, o_shamt})),
                           32'($sampled({exp_imm, exp_shamt})));
   a_nop: assert property (@(posedge i_clk) disable iff (i_rst) o_nop == exp_nop)
      else report_mismatch("o_nop", 32'($sampled(o_nop)), 32'($sampled(exp_nop)));
   a_dec: assert property (@(posedge i_clk) disable iff (i_rst)
      {o_rtype, o_store, o_branch, o_branch_taken, o_jump_reg, o_jump_imm, o_halt} ==
      {op == OP_RTYPE, m_mem.wr_en, m_flags.is_branch, m_taken, m_flags.jump_reg,
       m_flags.jump_imm, i_valid && (op == OP_HLT)})
      else report_mismatch(
         "o_rtype/o_store/o_branch/o_branch_taken/o_jump_reg/o_jump_imm/o_halt",
         32'($sampled({o_rtype, o_store, o_branch, o_branch_taken, o_jump_reg,
                       o_jump_imm, o_halt})),
         32'($sampled({op == OP_RTYPE, m_mem.wr_en, m_flags.is_branch, m_taken,
                       m_flags.jump_reg, m_flags.jump_imm, i_valid && (op == OP_HLT)})));
   a_jaddr: assert property (@(posedge i_clk) disable iff (i_rst)
      o_jump_reg_addr == shadow[f_rs])
      else report_mismatch("o_jump_reg_addr", $sampled(o_jump_reg_addr),
                           $sampled(shadow[f_rs]));
   a_jindex: assert property (@(posedge i_clk) disable iff (i_rst)
      o_jump_index == i_instruction[25:0])
      else report_mismatch("o_jump_index", 32'($sampled(o_jump_index)),
                           32'($sampled(i_instruction[25:0])));

   always @(posedge i_clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Simulation FAILED");
         $fatal(1);
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////////////////////

   function automatic word_t r_instr(func_t f, reg_addr_t s, reg_addr_t t, reg_addr_t d,
                                     shamt_t sh);
      return {OP_RTYPE, s, t, d, sh, f};
   endfunction

   function automatic word_t i_instr(opcode_t o, reg_addr_t s, reg_addr_t t, imm_t im);
      return {o, s, t, im};
   endfunction

   task automatic drive(input logic valid, input word_t instr, input logic we,
                        input reg_addr_t waddr, input word_t wdata);
      @(negedge i_clk);
      i_valid        <= valid;
      i_instruction  <= instr;
      i_pc           <= i_pc + 32'd4;
      i_regfile_we   <= we;
      i_regfile_addr <= waddr;
      i_regfile_data <= wdata;
      i_fwd_sel_a    <= 1'b0;
      i_fwd_sel_b    <= 1'b0;
   endtask

   task automatic issue_fwd(input word_t instr, input logic sa, input logic sb,
                            input word_t da, input word_t db);
      drive(1'b1, instr, 1'b0, '0, '0);
      i_fwd_sel_a  <= sa;
      i_fwd_sel_b  <= sb;
      i_fwd_data_a <= da;
      i_fwd_data_b <= db;
   endtask

   initial begin
      func_t   fn_list [15];
      opcode_t op_list [15];
      word_t   r;
      fn_list = '{FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV, FN_ADDU, FN_SUBU,
                  FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_JR, FN_JALR};
      op_list = '{OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU, OP_SB, OP_SH, OP_SW,
                  OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_SLTI};
      seed = 32'h9abd;
      cycle_count = 0;
      i_rst = 1'b1;
      i_valid = 1'b0;
      i_instruction = '0;
      i_pc = '0;
      i_regfile_we = 1'b0;
      i_regfile_addr = '0;
      i_regfile_data = '0;
      i_fwd_sel_a = 1'b0;
      i_fwd_sel_b = 1'b0;
      i_fwd_data_a = '0;
      i_fwd_data_b = '0;
      repeat (8) @(negedge i_clk);
      i_rst <= 1'b0;

      // Fill registers 1 to 31
      for (int i = 1; i < 32; i++) begin
         drive(1'b1, '0, 1'b1, 5'(i), $random(seed));
      end

      // Every function and opcode with one destination 0 case per group
      foreach (fn_list[k]) begin
         r = $random(seed);
         drive(1'b1, r_instr(fn_list[k], r[4:0], r[9:5], r[14:10], r[19:15]), 1'b0, '0, '0);
      end
      drive(1'b1, r_instr(FN_ADDU, 5'd3, 5'd4, 5'd0, 5'd0), 1'b0, '0, '0);
      foreach (op_list[k]) begin
         r = $random(seed);
         drive(1'b1, i_instr(op_list[k], r[4:0], r[9:5], r[31:16]), 1'b0, '0, '0);
      end
      drive(1'b1, i_instr(OP_ORI, 5'd2, 5'd0, 16'h00ff), 1'b0, '0, '0);

      // Branches from the register file and with forwarding
      drive(1'b1, i_instr(OP_BEQ, 5'd5, 5'd5, 16'h0010), 1'b0, '0, '0);
      drive(1'b1, i_instr(OP_BEQ, 5'd5, 5'd6, 16'h0010), 1'b0, '0, '0);
      drive(1'b1, i_instr(OP_BNE, 5'd5, 5'd6, 16'h0020), 1'b0, '0, '0);
      drive(1'b1, i_instr(OP_BNE, 5'd7, 5'd7, 16'h0020), 1'b0, '0, '0);
      issue_fwd(i_instr(OP_BEQ, 5'd5, 5'd6, 16'h0004), 1'b1, 1'b1, 32'h1234, 32'h1234);
      issue_fwd(i_instr(OP_BEQ, 5'd5, 5'd5, 16'h0004), 1'b1, 1'b0, 32'h5678, 32'h0);
      issue_fwd(i_instr(OP_BNE, 5'd8, 5'd9, 16'h0008), 1'b0, 1'b1, 32'h0, 32'habcd);

      // Jumps
      drive(1'b1, {OP_J, 26'h0123456}, 1'b0, '0, '0);
      drive(1'b1, {OP_JAL, 26'h3abcdef}, 1'b0, '0, '0);
      drive(1'b1, r_instr(FN_JR, 5'd9, 5'd0, 5'd0, 5'd0), 1'b0, '0, '0);
      drive(1'b1, r_instr(FN_JALR, 5'd10, 5'd0, 5'd31, 5'd0), 1'b0, '0, '0);

      // Stalls with pending writes, then read the targets back
      repeat (3) drive(1'b0, r_instr(FN_OR, 5'd1, 5'd2, 5'd3, 5'd0), 1'b1, 5'd9, 32'hdead);
      repeat (2) drive(1'b1, {OP_HLT, 26'h0}, 1'b1, 5'd10, 32'hbeef);
      drive(1'b1, r_instr(FN_ADDU, 5'd9, 5'd10, 5'd11, 5'd0), 1'b0, '0, '0);

      // Unknown opcode and function code
      drive(1'b1, i_instr(6'b010000, 5'd1, 5'd2, 16'h1111), 1'b0, '0, '0);
      drive(1'b1, r_instr(6'b111000, 5'd1, 5'd2, 5'd3, 5'd0), 1'b0, '0, '0);
      repeat (3) drive(1'b0, '0, 1'b0, '0, '0);
      @(negedge i_clk);
      $display("Simulation PASSED");
      $finish;
   end

endmodule

// File: flist.f
hdl/decode_pkg.sv
hdl/decode_control.sv
hdl/register_file.sv
hdl/branch_resolve.sv
hdl/id_ex_latch.sv
hdl/instruction_decode.sv
sim/decode_assert.sv
sim/tb_instruction_decode.sv

// File: Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := tb_instruction_decode
FLIST     := flist.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)

run: compile
	set -o pipefail 2>/dev/null; ./$(SIM) | tee /dev/stderr | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)
